// ==== gpio_top.f ====
+incdir+source
source/gpio_pkg.sv
source/gpio_sync.sv
source/gpio_irq.sv
source/gpio_regs.sv
source/gpio_bus_bridge.sv
source/gpio_top.sv
testbench/gpio_checker.sv
testbench/gpio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module gpio_tb -f gpio_top.f

out=$(./obj_dir/Vgpio_tb) || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"

# pass only when the testbench reported it
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

// ==== source/gpio_bus_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// bus bridge: request split into register strobes, registered response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_bus_bridge (
    input  logic                     clk,
    input  logic                     rst,
    // system bus
    input  logic                     req_vld,  // one cycle request strobe
    input  logic                     req_wen,  // 1 write, 0 read
    input  logic [`GPIO_BUS_ADR-1:0] req_adr,  // byte address
    input  logic [`GPIO_BUS_DAT-1:0] req_wdt,
    output logic                     rsp_vld,  // one cycle after req_vld
    output logic [`GPIO_BUS_DAT-1:0] rsp_rdt,  // 0 for writes
    // register bank
    output logic                     reg_wen,
    output logic                     reg_ren,
    output gpio_pkg::gpio_reg_e      reg_idx,
    output logic [`GPIO_BUS_DAT-1:0] reg_wdt,
    input  logic [`GPIO_BUS_DAT-1:0] reg_rdt
);

    localparam int IDX_W = $clog2(gpio_pkg::GPIO_REG_NUM);  // word index bits

    //////////////////////////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////////////////////////

    assign reg_wen = req_vld &  req_wen;
    assign reg_ren = req_vld & ~req_wen;
    assign reg_idx = gpio_pkg::gpio_reg_e'(req_adr[IDX_W+1:2]);  // byte offset dropped
    assign reg_wdt = req_wdt;

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= req_vld;  // fixed 1 cycle latency
        end
    end

    // data only loaded on a request
    always_ff @(posedge clk) begin
        if (req_vld) begin
            rsp_rdt <= reg_ren ? reg_rdt : '0;  // writes answer with 0
        end
    end

endmodule

// ==== source/gpio_irq.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO interrupt unit: level/edge detect, sticky status, irq output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_irq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`GPIO_WIDTH-1:0] in_dat,   // synchronized inputs
    input  logic [`GPIO_WIDTH-1:0] irq_ena,  // per-bit enable
    input  logic [`GPIO_WIDTH-1:0] irq_mod,  // 0 level, 1 edge
    input  logic [`GPIO_WIDTH-1:0] irq_pol,  // 0 low/falling, 1 high/rising
    input  logic [`GPIO_WIDTH-1:0] sts_clr,  // write-1-to-clear vector
    output logic [`GPIO_WIDTH-1:0] irq_sts,  // status read back
    output logic                   irq       // combined request
);

    logic [`GPIO_WIDTH-1:0] irq_val;  // active value per bit
    logic [`GPIO_WIDTH-1:0] irq_dly;  // previous active value, edge bits only
    logic [`GPIO_WIDTH-1:0] irq_ris;  // rise into active polarity
    logic [`GPIO_WIDTH-1:0] irq_edg;  // sticky edge flags

    //////////////////////////////////////////////////////////////////////
    // active value
    //////////////////////////////////////////////////////////////////////

    // 1 when the pin sits at its active polarity
    // enable applied early, disabled bits never toggle downstream
    assign irq_val = ~(in_dat ^ irq_pol) & irq_ena;

    // delay only the edge mode bits
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq_dly <= '0;
        end else begin
            irq_dly <= irq_val & irq_mod;
        end
    end

    assign irq_ris = irq_val & ~irq_dly & irq_mod;  // one direction only

    //////////////////////////////////////////////////////////////////////
    // sticky edge status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq_edg <= '0;
        end else begin
            // set term last, a fresh edge beats a clear on the same bit
            irq_edg <= (irq_edg & ~sts_clr) | irq_ris;
        end
    end

    // level bits show the live value, edge bits the sticky flag
    assign irq_sts = (irq_val & ~irq_mod) | (irq_edg & irq_mod & irq_ena);

    //////////////////////////////////////////////////////////////////////
    // combined request
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= |irq_sts;  // registered, glitch free
        end
    end

endmodule

// ==== source/gpio_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO register map: register index type and register count
//////////////////////////////////////////////////////////////////////

package gpio_pkg;

    // word register count in the map
    localparam int GPIO_REG_NUM = 8;

    // register index, address bits [4:2]
    typedef enum logic [2:0] {
        REG_OE      = 3'd0,  // output enable
        REG_OD      = 3'd1,  // output data
        REG_IE      = 3'd2,  // input enable
        REG_ID      = 3'd3,  // input data, read only
        REG_IRQ_ENA = 3'd4,  // irq enable
        REG_IRQ_MOD = 3'd5,  // irq mode (0 level, 1 edge)
        REG_IRQ_POL = 3'd6,  // irq polarity (0 low/falling, 1 high/rising)
        REG_IRQ_STS = 3'd7   // irq status, write 1 to clear
    } gpio_reg_e;

endpackage

// ==== source/gpio_regs.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO register bank: config registers, write decode, read mux, pads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_regs (
    input  logic                    clk,
    input  logic                    rst,
    // register strobes from the bridge
    input  logic                    reg_wen,   // write strobe
    input  logic                    reg_ren,   // read strobe
    input  gpio_pkg::gpio_reg_e     reg_idx,   // register index
    input  logic [`GPIO_BUS_DAT-1:0] reg_wdt,  // write data
    output logic [`GPIO_BUS_DAT-1:0] reg_rdt,  // read data, combinational
    // pads
    output logic [`GPIO_WIDTH-1:0]  gpio_out,  // output data register
    output logic [`GPIO_WIDTH-1:0]  gpio_oe,   // output enable register
    // synchronizer
    output logic [`GPIO_WIDTH-1:0]  in_ena,    // input enable register
    input  logic [`GPIO_WIDTH-1:0]  in_dat,    // synchronized inputs
    // interrupt unit
    output logic [`GPIO_WIDTH-1:0]  irq_ena,
    output logic [`GPIO_WIDTH-1:0]  irq_mod,
    output logic [`GPIO_WIDTH-1:0]  irq_pol,
    output logic [`GPIO_WIDTH-1:0]  sts_clr,   // status clear pulse
    input  logic [`GPIO_WIDTH-1:0]  irq_sts
);

    localparam int DW = `GPIO_BUS_DAT;
    localparam int GW = `GPIO_WIDTH;

    // pins must fit in one bus word
    if (GW > DW) begin : gen_width_err
        $error("GPIO width %0d exceeds bus data width %0d", GW, DW);
    end

    logic [GW-1:0] wdt;  // write data cut to pin width

    assign wdt = reg_wdt[GW-1:0];

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            gpio_oe  <= '0;
            gpio_out <= '0;
            in_ena   <= '0;
            irq_ena  <= '0;
            irq_mod  <= '0;
            irq_pol  <= '0;
        end else if (reg_wen) begin
            case (reg_idx)
                gpio_pkg::REG_OE:      gpio_oe  <= wdt;
                gpio_pkg::REG_OD:      gpio_out <= wdt;
                gpio_pkg::REG_IE:      in_ena   <= wdt;
                gpio_pkg::REG_IRQ_ENA: irq_ena  <= wdt;
                gpio_pkg::REG_IRQ_MOD: irq_mod  <= wdt;
                gpio_pkg::REG_IRQ_POL: irq_pol  <= wdt;
                // REG_ID read only, REG_IRQ_STS goes to sts_clr
                default: ;
            endcase
        end
    end

    // write 1 to clear, only during a status write
    assign sts_clr = (reg_wen && reg_idx == gpio_pkg::REG_IRQ_STS) ? wdt : '0;

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    // zero extended to bus width
    // held at 0 between reads to keep the read path quiet
    always_comb begin
        reg_rdt = '0;
        if (reg_ren) begin
            case (reg_idx)
                gpio_pkg::REG_OE:      reg_rdt = DW'(gpio_oe);
                gpio_pkg::REG_OD:      reg_rdt = DW'(gpio_out);
                gpio_pkg::REG_IE:      reg_rdt = DW'(in_ena);
                gpio_pkg::REG_ID:      reg_rdt = DW'(in_dat);
                gpio_pkg::REG_IRQ_ENA: reg_rdt = DW'(irq_ena);
                gpio_pkg::REG_IRQ_MOD: reg_rdt = DW'(irq_mod);
                gpio_pkg::REG_IRQ_POL: reg_rdt = DW'(irq_pol);
                gpio_pkg::REG_IRQ_STS: reg_rdt = DW'(irq_sts);
                default:               reg_rdt = '0;
            endcase
        end
    end

endmodule

// ==== source/gpio_settings.svh ====
//////////////////////////////////////////////////////////////////////
// build-time sizes of the GPIO block: pin count, sync depth, bus widths
//////////////////////////////////////////////////////////////////////

`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// number of GPIO pins, 1 to 32, not above the bus data width
`define GPIO_WIDTH 16

// input synchronizer depth, at least 2 flops
`define GPIO_SYNC_STAGES 2

// system bus widths
`define GPIO_BUS_DAT 32  // data
`define GPIO_BUS_ADR 5   // byte address, top 3 bits pick the word register

`endif

// ==== source/gpio_sync.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO input synchronizer with per-bit input enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_sync (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`GPIO_WIDTH-1:0] gpio_in,  // asynchronous pad inputs
    input  logic [`GPIO_WIDTH-1:0] in_ena,   // input enable register
    output logic [`GPIO_WIDTH-1:0] in_dat    // synchronized, masked
);

    localparam int STAGES = `GPIO_SYNC_STAGES;

    // depth check at elaboration
    if (STAGES < 2) begin : gen_depth_err
        $error("gpio_sync needs at least 2 stages, got %0d", STAGES);
    end

    logic [STAGES-1:0][`GPIO_WIDTH-1:0] sync_q;  // [0] is the metastable stage

    //////////////////////////////////////////////////////////////////////
    // shift chain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            // unused pins park at 0, chain stays quiet
            sync_q[0] <= gpio_in & in_ena;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // disabling a bit takes effect at once, no chain flush wait
    assign in_dat = sync_q[STAGES-1] & in_ena;

endmodule

// ==== source/gpio_top.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO peripheral top: bridge, register bank, synchronizer, irq unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_top (
    input  logic                     clk,
    input  logic                     rst,
    // system bus
    input  logic                     req_vld,
    input  logic                     req_wen,
    input  logic [`GPIO_BUS_ADR-1:0] req_adr,
    input  logic [`GPIO_BUS_DAT-1:0] req_wdt,
    output logic                     rsp_vld,
    output logic [`GPIO_BUS_DAT-1:0] rsp_rdt,
    // pads
    input  logic [`GPIO_WIDTH-1:0]   gpio_in,
    output logic [`GPIO_WIDTH-1:0]   gpio_out,
    output logic [`GPIO_WIDTH-1:0]   gpio_oe,
    // interrupt
    output logic                     irq
);

    // bridge to register bank
    logic                     reg_wen;
    logic                     reg_ren;
    gpio_pkg::gpio_reg_e      reg_idx;
    logic [`GPIO_BUS_DAT-1:0] reg_wdt;
    logic [`GPIO_BUS_DAT-1:0] reg_rdt;

    // register bank to sync and irq
    logic [`GPIO_WIDTH-1:0]   in_ena;
    logic [`GPIO_WIDTH-1:0]   in_dat;
    logic [`GPIO_WIDTH-1:0]   irq_ena;
    logic [`GPIO_WIDTH-1:0]   irq_mod;
    logic [`GPIO_WIDTH-1:0]   irq_pol;
    logic [`GPIO_WIDTH-1:0]   sts_clr;
    logic [`GPIO_WIDTH-1:0]   irq_sts;

    gpio_bus_bridge u_bridge (
        .clk     (clk),
        .rst     (rst),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_wdt (req_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .reg_wen (reg_wen),
        .reg_ren (reg_ren),
        .reg_idx (reg_idx),
        .reg_wdt (reg_wdt),
        .reg_rdt (reg_rdt)
    );

    gpio_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_wen  (reg_wen),
        .reg_ren  (reg_ren),
        .reg_idx  (reg_idx),
        .reg_wdt  (reg_wdt),
        .reg_rdt  (reg_rdt),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .in_ena   (in_ena),
        .in_dat   (in_dat),
        .irq_ena  (irq_ena),
        .irq_mod  (irq_mod),
        .irq_pol  (irq_pol),
        .sts_clr  (sts_clr),
        .irq_sts  (irq_sts)
    );

    gpio_sync u_sync (
        .clk     (clk),
        .rst     (rst),
        .gpio_in (gpio_in),
        .in_ena  (in_ena),
        .in_dat  (in_dat)
    );

    gpio_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .in_dat  (in_dat),   // straight from the synchronizer
        .irq_ena (irq_ena),
        .irq_mod (irq_mod),
        .irq_pol (irq_pol),
        .sts_clr (sts_clr),
        .irq_sts (irq_sts),
        .irq     (irq)
    );

endmodule

// ==== testbench/gpio_checker.sv ====
//////////////////////////////////////////////////////////////////////
// bus response and irq protocol assertions, bound into gpio_top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_vld,
    input logic                   rsp_vld,
    input logic                   irq,
    input logic [`GPIO_WIDTH-1:0] irq_ena   // internal enable register
);

    // one response per request, one cycle later, never on its own
    rsp_follows_req: assert property (
        @(posedge clk) disable iff (rst) rsp_vld == $past(req_vld)
    ) else $error("rsp_vld does not match req_vld of the previous cycle");

    // outputs quiet while reset is held
    quiet_in_reset: assert property (
        @(posedge clk) rst |-> (!rsp_vld && !irq)
    ) else $error("rsp_vld or irq high during reset");

    // irq is registered, so it sees the enable of the previous cycle
    irq_needs_enable: assert property (
        @(posedge clk) disable iff (rst) (~|$past(irq_ena)) |-> !irq
    ) else $error("irq high with all irq enable bits clear");

endmodule

bind gpio_top gpio_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .req_vld (req_vld),
    .rsp_vld (rsp_vld),
    .irq     (irq),
    .irq_ena (irq_ena)
);

// ==== testbench/gpio_tb.sv ====
//////////////////////////////////////////////////////////////////////
// GPIO testbench: clock, reset, LFSR, bus tasks, directed tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "gpio_settings.svh"

module gpio_tb;

    localparam int          GW       = `GPIO_WIDTH;
    localparam int          TIMEOUT  = 50;  // polls per wait
    localparam logic [31:0] PIN_MASK = 32'((64'd1 << GW) - 64'd1);

    logic                     clk;
    logic                     rst;
    logic                     req_vld;
    logic                     req_wen;
    logic [`GPIO_BUS_ADR-1:0] req_adr;
    logic [`GPIO_BUS_DAT-1:0] req_wdt;
    logic                     rsp_vld;
    logic [`GPIO_BUS_DAT-1:0] rsp_rdt;
    logic [GW-1:0]            gpio_in;
    logic [GW-1:0]            gpio_out;
    logic [GW-1:0]            gpio_oe;
    logic                     irq;
    logic [31:0]              lfsr_state;  // random source

    gpio_top UUT (
        .clk      (clk),
        .rst      (rst),
        .req_vld  (req_vld),
        .req_wen  (req_wen),
        .req_adr  (req_adr),
        .req_wdt  (req_wdt),
        .rsp_vld  (rsp_vld),
        .rsp_rdt  (rsp_rdt),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .irq      (irq)
    );

    always #20 clk = ~clk;  // 40 ns period

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;  // drive and sample clear of the edge
    endtask

    task automatic stop_fail;
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            stop_fail();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus access with one request and its response a cycle later
    //////////////////////////////////////////////////////////////////////

    task automatic bus_access(input gpio_pkg::gpio_reg_e idx, input logic wen,
                              input logic [31:0] data, output logic [31:0] rdt);
        logic [31:0] lo;
        rand_bits(2, lo);  // byte offset is don't care
        req_vld = 1'b1;
        req_wen = wen;
        req_adr = {idx, lo[1:0]};
        req_wdt = data;
        next_cycle();
        req_vld = 1'b0;
        req_wen = 1'b0;
        check_eq(32'(rsp_vld), 32'd1, "response strobe one cycle after request");
        rdt = rsp_rdt;
    endtask

    task automatic bus_write(input gpio_pkg::gpio_reg_e idx, input logic [31:0] data);
        logic [31:0] rdt;
        bus_access(idx, 1'b1, data, rdt);
        check_eq(rdt, 32'd0, "write response data");
    endtask

    task automatic bus_read(input gpio_pkg::gpio_reg_e idx, output logic [31:0] data);
        bus_access(idx, 1'b0, 32'd0, data);
    endtask

    task automatic check_reg(input gpio_pkg::gpio_reg_e idx, input logic [31:0] exp,
                             input string what);
        logic [31:0] got;
        bus_read(idx, got);
        check_eq(got, exp, what);
    endtask

    // poll a register until it reads exp
    task automatic wait_reg(input gpio_pkg::gpio_reg_e idx, input logic [31:0] exp,
                            input string what);
        logic [31:0] got;
        bit          hit;
        hit = 1'b0;
        got = '0;
        for (int i = 0; i < TIMEOUT && !hit; i++) begin
            bus_read(idx, got);
            hit = (got == exp);
        end
        assert (hit) else begin
            $display("timeout at %t: %s never read 0x%08h, last read 0x%08h",
                     $time, what, exp, got);
            stop_fail();
        end
    endtask

    task automatic wait_irq(input logic exp, input string what);
        bit hit;
        hit = (irq == exp);
        for (int i = 0; i < TIMEOUT && !hit; i++) begin
            next_cycle();
            hit = (irq == exp);
        end
        assert (hit) else begin
            $display("timeout at %t: irq never went to %0d (%s)", $time, exp, what);
            stop_fail();
        end
    endtask

    task automatic clear_config;
        bus_write(gpio_pkg::REG_IRQ_ENA, '0);  // enable first so no stray edges
        bus_write(gpio_pkg::REG_IRQ_MOD, '0);
        bus_write(gpio_pkg::REG_IRQ_POL, '0);
        bus_write(gpio_pkg::REG_IE, '0);
        bus_write(gpio_pkg::REG_OE, '0);
        bus_write(gpio_pkg::REG_OD, '0);
        bus_write(gpio_pkg::REG_IRQ_STS, PIN_MASK);  // drop sticky flags
        gpio_in = '0;
        wait_irq(1'b0, "config cleared");
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state;
        check_eq(32'(gpio_out), 32'd0, "gpio_out after reset");
        check_eq(32'(gpio_oe), 32'd0, "gpio_oe after reset");
        check_eq(32'(irq), 32'd0, "irq after reset");
        for (int i = 0; i < gpio_pkg::GPIO_REG_NUM; i++) begin
            check_reg(gpio_pkg::gpio_reg_e'(i[2:0]), 32'd0,
                      $sformatf("register %0d after reset", i));
        end
    endtask

    task automatic register_access;
        gpio_pkg::gpio_reg_e idx;
        logic [31:0]         val;
        logic [31:0]         model [gpio_pkg::GPIO_REG_NUM];
        for (int i = 0; i < gpio_pkg::GPIO_REG_NUM; i++) begin
            idx = gpio_pkg::gpio_reg_e'(i[2:0]);
            model[i] = '0;
            if (idx != gpio_pkg::REG_ID && idx != gpio_pkg::REG_IRQ_STS) begin
                rand_bits(32, val);
                bus_write(idx, val);
                model[i] = val & PIN_MASK;  // upper bits dropped
            end
        end
        for (int i = 0; i < gpio_pkg::GPIO_REG_NUM; i++) begin
            idx = gpio_pkg::gpio_reg_e'(i[2:0]);
            if (idx != gpio_pkg::REG_ID && idx != gpio_pkg::REG_IRQ_STS) begin
                check_reg(idx, model[i], $sformatf("read back of register %0d", i));
            end
        end
        check_eq(32'(gpio_oe), model[int'(gpio_pkg::REG_OE)], "gpio_oe pads");
        check_eq(32'(gpio_out), model[int'(gpio_pkg::REG_OD)], "gpio_out pads");
        clear_config();
    endtask

    task automatic input_path;
        logic [31:0] ie;
        logic [31:0] pins;
        logic [31:0] junk;
        rand_bits(GW, ie);
        rand_bits(GW, pins);
        bus_write(gpio_pkg::REG_IE, ie);
        gpio_in = pins[GW-1:0];
        wait_reg(gpio_pkg::REG_ID, ie & pins, "masked input data");
        // read only register ignores the write
        rand_bits(32, junk);
        bus_write(gpio_pkg::REG_ID, junk);
        check_reg(gpio_pkg::REG_ID, ie & pins, "input data after a write to REG_ID");
        clear_config();
    endtask

    task automatic level_irq;
        logic [31:0] r;
        logic [31:0] bitm;
        int          p;
        rand_bits(5, r);
        p = int'(r) % GW;
        bitm = 32'd1 << p;
        gpio_in = '0;
        bus_write(gpio_pkg::REG_IE, bitm);
        bus_write(gpio_pkg::REG_IRQ_POL, bitm);  // active high
        bus_write(gpio_pkg::REG_IRQ_MOD, '0);    // level
        bus_write(gpio_pkg::REG_IRQ_ENA, bitm);
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "level status, pin inactive");
        check_eq(32'(irq), 32'd0, "irq with level pin low, active high");
        gpio_in[p] = 1'b1;
        wait_irq(1'b1, "level pin high, active high");
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "level status, pin active high");
        bus_write(gpio_pkg::REG_IRQ_STS, bitm);  // clear has no hold on level bits
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "level status after write 1");
        check_eq(32'(irq), 32'd1, "irq after write 1 to level status");
        gpio_in[p] = 1'b0;
        wait_irq(1'b0, "level pin back low");
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "level status, pin released");
        // active low
        bus_write(gpio_pkg::REG_IRQ_POL, '0);
        wait_irq(1'b1, "level pin low, active low");
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "level status, pin active low");
        gpio_in[p] = 1'b1;
        wait_irq(1'b0, "level pin high, active low");
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "level status, pin inactive high");
        gpio_in[p] = 1'b0;
        wait_irq(1'b1, "level pin low again");
        bus_write(gpio_pkg::REG_IRQ_ENA, '0);
        wait_irq(1'b0, "level enable removed");
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "level status with enable off");
        clear_config();
    endtask

    task automatic edge_irq;
        logic [31:0] r;
        logic [31:0] bitm;
        logic [31:0] idle;  // REG_ID with the pin inactive
        int          p;
        logic        pol;
        rand_bits(5, r);
        p = int'(r) % GW;
        bitm = 32'd1 << p;
        rand_bits(1, r);
        pol = r[0];
        idle = pol ? 32'd0 : bitm;
        gpio_in = '0;
        gpio_in[p] = ~pol;
        bus_write(gpio_pkg::REG_IE, bitm);
        bus_write(gpio_pkg::REG_IRQ_POL, pol ? bitm : 32'd0);
        bus_write(gpio_pkg::REG_IRQ_MOD, bitm);  // edge
        wait_reg(gpio_pkg::REG_ID, idle, "edge pin idle");
        bus_write(gpio_pkg::REG_IRQ_ENA, bitm);
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "edge status before any edge");
        gpio_in[p] = pol;  // into active polarity
        wait_irq(1'b1, "edge into active polarity");
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "edge status after edge");
        gpio_in[p] = ~pol;
        wait_reg(gpio_pkg::REG_ID, idle, "edge pin back to idle");
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "sticky status after pin returns");
        check_eq(32'(irq), 32'd1, "irq held by sticky status");
        rand_bits(32, r);
        bus_write(gpio_pkg::REG_IRQ_STS, r & ~bitm);  // zero on our bit
        check_reg(gpio_pkg::REG_IRQ_STS, bitm, "sticky status after write 0");
        bus_write(gpio_pkg::REG_IRQ_STS, bitm);
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "sticky status after write 1");
        wait_irq(1'b0, "edge status cleared");
        // set again and clear while held active before leaving
        gpio_in[p] = pol;
        wait_irq(1'b1, "second edge into active polarity");
        bus_write(gpio_pkg::REG_IRQ_STS, bitm);
        wait_irq(1'b0, "cleared with pin still active");
        gpio_in[p] = ~pol;
        wait_reg(gpio_pkg::REG_ID, idle, "edge pin leaves active polarity");
        check_reg(gpio_pkg::REG_IRQ_STS, 32'd0, "no status on edge out of polarity");
        check_eq(32'(irq), 32'd0, "no irq on edge out of polarity");
        clear_config();
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk        = 1'b0;
        rst        = 1'b1;
        req_vld    = 1'b0;
        req_wen    = 1'b0;
        req_adr    = '0;
        req_wdt    = '0;
        gpio_in    = '0;
        lfsr_state = 32'h5ae4_f397;
        repeat (3) @(posedge clk);  // reset held 3 cycles
        #1;
        rst = 1'b0;
        reset_state();
        register_access();
        input_path();
        level_irq();
        edge_irq();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
